/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

    localparam int xlen = 32;

    // addi x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu operations
    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10;

    // operand a source
    localparam logic [1:0] src_a_rs1  = 2'd0;
    localparam logic [1:0] src_a_pc   = 2'd1;
    localparam logic [1:0] src_a_zero = 2'd2;

    // operand b source
    localparam logic [1:0] src_b_rs2  = 2'd0;
    localparam logic [1:0] src_b_imm  = 2'd1;
    localparam logic [1:0] src_b_four = 2'd2;

    // register write-back source
    localparam logic [1:0] wb_sel_alu = 2'd0;
    localparam logic [1:0] wb_sel_mem = 2'd1;
    localparam logic [1:0] wb_sel_pc4 = 2'd2;

endpackage

/* id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if;
    logic [rv_pipe_pkg::xlen-1:0] pc;
    logic [rv_pipe_pkg::xlen-1:0] pc_plus_4;
    logic                         branch_estimation;
    logic [31:0]                  instruction;
    logic                         jump;
    logic                         branch;
    logic [3:0]                   alu_op;
    logic [1:0]                   alu_src_a_select;
    logic [1:0]                   alu_src_b_select;
    logic                         memory_read;
    logic                         memory_write;
    logic [1:0]                   register_file_write_data_select;
    logic                         register_write_enable;
    logic [2:0]                   funct3;
    logic [4:0]                   rd;
    logic [4:0]                   rs1;
    logic [4:0]                   rs2;
    logic [rv_pipe_pkg::xlen-1:0] imm;
    logic [rv_pipe_pkg::xlen-1:0] read_data1;
    logic [rv_pipe_pkg::xlen-1:0] read_data2;

    modport producer (
        output pc, pc_plus_4, branch_estimation, instruction, jump, branch, alu_op,
               alu_src_a_select, alu_src_b_select, memory_read, memory_write,
               register_file_write_data_select, register_write_enable, funct3, rd,
               rs1, rs2, imm, read_data1, read_data2
    );

    modport consumer (
        input pc, pc_plus_4, branch_estimation, instruction, jump, branch, alu_op,
              alu_src_a_select, alu_src_b_select, memory_read, memory_write,
              register_file_write_data_select, register_write_enable, funct3, rd,
              rs1, rs2, imm, read_data1, read_data2
    );
endinterface

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  logic [31:0]                  instruction,
    output logic                         jump,
    output logic                         branch,
    output logic                         memory_read,
    output logic                         memory_write,
    output logic                         register_write_enable,
    output logic [3:0]                   alu_op,
    output logic [1:0]                   alu_src_a_select,
    output logic [1:0]                   alu_src_b_select,
    output logic [1:0]                   register_file_write_data_select,
    output logic [4:0]                   rd,
    output logic [4:0]                   rs1,
    output logic [4:0]                   rs2,
    output logic [2:0]                   funct3,
    output logic [rv_pipe_pkg::xlen-1:0] imm
);

    logic [6:0] opcode;
    logic [3:0] arith_op;

    assign opcode = instruction[6:0];
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];

    // bit 30 picks sra over srl, and sub over add only for register ops
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == rv_pipe_pkg::op_reg && instruction[30]) ?
                               rv_pipe_pkg::alu_sub : rv_pipe_pkg::alu_add;
            3'b001: arith_op = rv_pipe_pkg::alu_sll;
            3'b010: arith_op = rv_pipe_pkg::alu_slt;
            3'b011: arith_op = rv_pipe_pkg::alu_sltu;
            3'b100: arith_op = rv_pipe_pkg::alu_xor;
            3'b101: arith_op = instruction[30] ? rv_pipe_pkg::alu_sra : rv_pipe_pkg::alu_srl;
            3'b110: arith_op = rv_pipe_pkg::alu_or;
            default: arith_op = rv_pipe_pkg::alu_and;
        endcase
    end

    always_comb begin
        jump                            = 1'b0;
        branch                          = 1'b0;
        memory_read                     = 1'b0;
        memory_write                    = 1'b0;
        register_write_enable           = 1'b0;
        alu_op                          = rv_pipe_pkg::alu_add;
        alu_src_a_select                = rv_pipe_pkg::src_a_rs1;
        alu_src_b_select                = rv_pipe_pkg::src_b_rs2;
        register_file_write_data_select = rv_pipe_pkg::wb_sel_alu;
        imm                             = '0;
        case (opcode)
            rv_pipe_pkg::op_lui: begin
                register_write_enable = 1'b1;
                alu_op                = rv_pipe_pkg::alu_pass_b;
                alu_src_a_select      = rv_pipe_pkg::src_a_zero;
                alu_src_b_select      = rv_pipe_pkg::src_b_imm;
                imm                   = {instruction[31:12], 12'b0};
            end
            rv_pipe_pkg::op_auipc: begin
                register_write_enable = 1'b1;
                alu_src_a_select      = rv_pipe_pkg::src_a_pc;
                alu_src_b_select      = rv_pipe_pkg::src_b_imm;
                imm                   = {instruction[31:12], 12'b0};
            end
            rv_pipe_pkg::op_jal, rv_pipe_pkg::op_jalr: begin
                // link value pc + 4 comes out of the alu
                jump                            = 1'b1;
                register_write_enable           = 1'b1;
                alu_src_a_select                = rv_pipe_pkg::src_a_pc;
                alu_src_b_select                = rv_pipe_pkg::src_b_four;
                register_file_write_data_select = rv_pipe_pkg::wb_sel_pc4;
                if (opcode == rv_pipe_pkg::op_jal) begin
                    imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                           instruction[20], instruction[30:21], 1'b0};
                end else begin
                    imm = {{20{instruction[31]}}, instruction[31:20]};
                end
            end
            rv_pipe_pkg::op_branch: begin
                branch = 1'b1;
                alu_op = rv_pipe_pkg::alu_sub;
                imm    = {{19{instruction[31]}}, instruction[31], instruction[7],
                          instruction[30:25], instruction[11:8], 1'b0};
            end
            rv_pipe_pkg::op_load: begin
                memory_read                     = 1'b1;
                register_write_enable           = 1'b1;
                alu_src_b_select                = rv_pipe_pkg::src_b_imm;
                register_file_write_data_select = rv_pipe_pkg::wb_sel_mem;
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            rv_pipe_pkg::op_store: begin
                memory_write     = 1'b1;
                alu_src_b_select = rv_pipe_pkg::src_b_imm;
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            rv_pipe_pkg::op_imm: begin
                register_write_enable = 1'b1;
                alu_op                = arith_op;
                alu_src_b_select      = rv_pipe_pkg::src_b_imm;
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            rv_pipe_pkg::op_reg: begin
                register_write_enable = 1'b1;
                alu_op                = arith_op;
            end
            default: begin
                // fence, system and anything unknown fall through as a nop
            end
        endcase
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    output logic [rv_pipe_pkg::xlen-1:0] read_data1,
    output logic [rv_pipe_pkg::xlen-1:0] read_data2,
    input  logic                         write_enable,
    input  logic [4:0]                   write_rd,
    input  logic [rv_pipe_pkg::xlen-1:0] write_data
);

    // x0 has no storage
    logic [rv_pipe_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_rd != 5'd0) begin
            regs[write_rd] <= write_data;
        end
    end

    // no write bypass, same-cycle reads see the old value
    assign read_data1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign read_data2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* id_ex_register.sv */
`timescale 1ns/1ps

module id_ex_register (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        redirect,
    input  logic        stall,
    id_ex_if.consumer   id_side,
    id_ex_if.producer   ex_side
);

    // instruction word on top, every other field below it
    logic [5*rv_pipe_pkg::xlen+65:0] id_word;
    logic [5*rv_pipe_pkg::xlen+65:0] nop_word;
    logic [5*rv_pipe_pkg::xlen+65:0] stage_q;

    assign id_word = {id_side.instruction, id_side.pc, id_side.pc_plus_4,
                      id_side.branch_estimation, id_side.jump, id_side.branch,
                      id_side.alu_op, id_side.alu_src_a_select, id_side.alu_src_b_select,
                      id_side.memory_read, id_side.memory_write,
                      id_side.register_file_write_data_select, id_side.register_write_enable,
                      id_side.funct3, id_side.rd, id_side.rs1, id_side.rs2, id_side.imm,
                      id_side.read_data1, id_side.read_data2};

    assign nop_word = {rv_pipe_pkg::nop_instr, {(5*rv_pipe_pkg::xlen+34){1'b0}}};

    // flush wins over stall, a taken redirect squashes the next slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_q <= nop_word;
        end else if (flush || redirect) begin
            stage_q <= nop_word;
        end else if (!stall) begin
            stage_q <= id_word;
        end
    end

    assign {ex_side.instruction, ex_side.pc, ex_side.pc_plus_4,
            ex_side.branch_estimation, ex_side.jump, ex_side.branch,
            ex_side.alu_op, ex_side.alu_src_a_select, ex_side.alu_src_b_select,
            ex_side.memory_read, ex_side.memory_write,
            ex_side.register_file_write_data_select, ex_side.register_write_enable,
            ex_side.funct3, ex_side.rd, ex_side.rs1, ex_side.rs2, ex_side.imm,
            ex_side.read_data1, ex_side.read_data2} = stage_q;

endmodule

/* ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    id_ex_if.consumer                    ex_side,
    output logic [rv_pipe_pkg::xlen-1:0] alu_result,
    output logic [rv_pipe_pkg::xlen-1:0] store_data,
    output logic                         redirect,
    output logic [rv_pipe_pkg::xlen-1:0] redirect_pc
);

    logic [rv_pipe_pkg::xlen-1:0] operand_a;
    logic [rv_pipe_pkg::xlen-1:0] operand_b;
    logic [rv_pipe_pkg::xlen-1:0] branch_target;
    logic [rv_pipe_pkg::xlen-1:0] jalr_target;
    logic                         condition;
    logic                         taken;

    always_comb begin
        case (ex_side.alu_src_a_select)
            rv_pipe_pkg::src_a_pc:   operand_a = ex_side.pc;
            rv_pipe_pkg::src_a_zero: operand_a = '0;
            default:                 operand_a = ex_side.read_data1;
        endcase
        case (ex_side.alu_src_b_select)
            rv_pipe_pkg::src_b_imm:  operand_b = ex_side.imm;
            rv_pipe_pkg::src_b_four: operand_b = rv_pipe_pkg::xlen'(4);
            default:                 operand_b = ex_side.read_data2;
        endcase
    end

    always_comb begin
        case (ex_side.alu_op)
            rv_pipe_pkg::alu_sub:    alu_result = operand_a - operand_b;
            rv_pipe_pkg::alu_sll:    alu_result = operand_a << operand_b[4:0];
            rv_pipe_pkg::alu_slt:    alu_result = rv_pipe_pkg::xlen'($signed(operand_a) <
                                                                    $signed(operand_b));
            rv_pipe_pkg::alu_sltu:   alu_result = rv_pipe_pkg::xlen'(operand_a < operand_b);
            rv_pipe_pkg::alu_xor:    alu_result = operand_a ^ operand_b;
            rv_pipe_pkg::alu_srl:    alu_result = operand_a >> operand_b[4:0];
            rv_pipe_pkg::alu_sra:    alu_result = $signed(operand_a) >>> operand_b[4:0];
            rv_pipe_pkg::alu_or:     alu_result = operand_a | operand_b;
            rv_pipe_pkg::alu_and:    alu_result = operand_a & operand_b;
            rv_pipe_pkg::alu_pass_b: alu_result = operand_b;
            default:                 alu_result = operand_a + operand_b;
        endcase
    end

    // branch compare works on register data, not on the alu operands
    always_comb begin
        case (ex_side.funct3)
            3'b000:  condition = ex_side.read_data1 == ex_side.read_data2;
            3'b001:  condition = ex_side.read_data1 != ex_side.read_data2;
            3'b100:  condition = $signed(ex_side.read_data1) < $signed(ex_side.read_data2);
            3'b101:  condition = $signed(ex_side.read_data1) >= $signed(ex_side.read_data2);
            3'b110:  condition = ex_side.read_data1 < ex_side.read_data2;
            3'b111:  condition = ex_side.read_data1 >= ex_side.read_data2;
            default: condition = 1'b0;
        endcase
    end

    assign taken         = ex_side.branch && condition;
    assign branch_target = ex_side.pc + ex_side.imm;
    assign jalr_target   = (ex_side.read_data1 + ex_side.imm) & ~rv_pipe_pkg::xlen'(1);
    assign store_data    = ex_side.read_data2;

    // fetch estimate wrong, or any jump
    assign redirect = ex_side.jump || (ex_side.branch && (taken != ex_side.branch_estimation));

    always_comb begin
        if (ex_side.jump && ex_side.instruction[6:0] == rv_pipe_pkg::op_jalr) begin
            redirect_pc = jalr_target;
        end else if (ex_side.branch && !taken) begin
            redirect_pc = ex_side.pc_plus_4;
        end else begin
            redirect_pc = branch_target;
        end
    end

endmodule

/* rv_id_ex_top.sv */
`timescale 1ns/1ps

module rv_id_ex_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         stall,
    input  logic [rv_pipe_pkg::xlen-1:0] id_pc,
    input  logic [rv_pipe_pkg::xlen-1:0] id_pc_plus_4,
    input  logic                         id_branch_estimation,
    input  logic [31:0]                  id_instruction,
    input  logic                         wb_write_enable,
    input  logic [4:0]                   wb_rd,
    input  logic [rv_pipe_pkg::xlen-1:0] wb_data,
    output logic [31:0]                  ex_instruction,
    output logic [4:0]                   ex_rd,
    output logic                         ex_register_write_enable,
    output logic                         ex_memory_read,
    output logic                         ex_memory_write,
    output logic [1:0]                   ex_write_data_select,
    output logic [rv_pipe_pkg::xlen-1:0] ex_alu_result,
    output logic [rv_pipe_pkg::xlen-1:0] ex_store_data,
    output logic                         redirect,
    output logic [rv_pipe_pkg::xlen-1:0] redirect_pc
);

    id_ex_if id_side ();
    id_ex_if ex_side ();

    assign id_side.pc                = id_pc;
    assign id_side.pc_plus_4         = id_pc_plus_4;
    assign id_side.branch_estimation = id_branch_estimation;
    assign id_side.instruction       = id_instruction;

    instr_decoder u_instr_decoder (
        .instruction                     (id_instruction),
        .jump                            (id_side.jump),
        .branch                          (id_side.branch),
        .memory_read                     (id_side.memory_read),
        .memory_write                    (id_side.memory_write),
        .register_write_enable           (id_side.register_write_enable),
        .alu_op                          (id_side.alu_op),
        .alu_src_a_select                (id_side.alu_src_a_select),
        .alu_src_b_select                (id_side.alu_src_b_select),
        .register_file_write_data_select (id_side.register_file_write_data_select),
        .rd                              (id_side.rd),
        .rs1                             (id_side.rs1),
        .rs2                             (id_side.rs2),
        .funct3                          (id_side.funct3),
        .imm                             (id_side.imm)
    );

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .rs1          (id_side.rs1),
        .rs2          (id_side.rs2),
        .read_data1   (id_side.read_data1),
        .read_data2   (id_side.read_data2),
        .write_enable (wb_write_enable),
        .write_rd     (wb_rd),
        .write_data   (wb_data)
    );

    id_ex_register u_id_ex_register (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .redirect (redirect),
        .stall    (stall),
        .id_side  (id_side.consumer),
        .ex_side  (ex_side.producer)
    );

    ex_stage u_ex_stage (
        .ex_side     (ex_side.consumer),
        .alu_result  (ex_alu_result),
        .store_data  (ex_store_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    assign ex_instruction           = ex_side.instruction;
    assign ex_rd                    = ex_side.rd;
    assign ex_register_write_enable = ex_side.register_write_enable;
    assign ex_memory_read           = ex_side.memory_read;
    assign ex_memory_write          = ex_side.memory_write;
    assign ex_write_data_select     = ex_side.register_file_write_data_select;

endmodule

/* rv_id_ex_properties.sv */
`timescale 1ns/1ps

module rv_id_ex_properties (
    input logic                            clk,
    input logic                            reset,
    input logic                            flush,
    input logic                            redirect,
    input logic                            stall,
    input logic                            register_write_enable,
    input logic                            memory_read,
    input logic                            memory_write,
    input logic [5*rv_pipe_pkg::xlen+65:0] stage
);

    // read by the testbench at the end of the run
    int failures = 0;

    // a squashed slot must not write anything
    squash_clears_controls: assert property (@(posedge clk) disable iff (reset)
        (flush || redirect) |=> (!register_write_enable && !memory_read && !memory_write))
        else begin
            $error("controls active in the slot after a flush or redirect");
            failures++;
        end

    squash_loads_nop: assert property (@(posedge clk) disable iff (reset)
        (flush || redirect) |=> (stage[5*rv_pipe_pkg::xlen+65 -: 32] == rv_pipe_pkg::nop_instr))
        else begin
            $error("slot after a flush or redirect is not a nop");
            failures++;
        end

    stall_holds_stage: assert property (@(posedge clk) disable iff (reset)
        (stall && !flush && !redirect) |=> $stable(stage))
        else begin
            $error("id/ex contents changed under stall");
            failures++;
        end

endmodule

bind id_ex_register rv_id_ex_properties u_rv_id_ex_properties (
    .clk                   (clk),
    .reset                 (reset),
    .flush                 (flush),
    .redirect              (redirect),
    .stall                 (stall),
    .register_write_enable (ex_side.register_write_enable),
    .memory_read           (ex_side.memory_read),
    .memory_write          (ex_side.memory_write),
    .stage                 (stage_q)
);

/* rv_id_ex_tb.sv */
`timescale 1ns/1ps

module rv_id_ex_tb;

    localparam int num_issue = 400;

    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [31:0] redirect_pc;
        logic [4:0]  rd;
        logic [1:0]  wb_sel;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        redirect;
        logic        check_alu;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        stall;
    logic [31:0] id_pc;
    logic [31:0] id_pc_plus_4;
    logic        id_branch_estimation;
    logic [31:0] id_instruction;
    logic        wb_write_enable;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] ex_instruction;
    logic [4:0]  ex_rd;
    logic        ex_register_write_enable;
    logic        ex_memory_read;
    logic        ex_memory_write;
    logic [1:0]  ex_write_data_select;
    logic [31:0] ex_alu_result;
    logic [31:0] ex_store_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    integer      seed = 80;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] mirror [0:31];
    logic        started = 1'b0;
    logic        slot_bubble = 1'b1;
    logic [31:0] slot_instr;
    expect_t     slot_exp;

    rv_id_ex_top u_rv_id_ex_top (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? x - y : x + y;
            3'b001: r = x << y[4:0];
            3'b010: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011: r = (x < y) ? 32'd1 : 32'd0;
            3'b100: r = x ^ y;
            3'b101: begin
                if (alt) r = $signed(x) >>> y[4:0];
                else r = x >> y[4:0];
            end
            3'b110: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    // expected ex-stage view of one instruction, from the rv32i rules
    function automatic expect_t ref_model(input logic [31:0] instr, input logic [31:0] pc,
                                          input logic est);
        expect_t     e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        taken;
        a = (instr[19:15] == 5'd0) ? 32'd0 : mirror[instr[19:15]];
        b = (instr[24:20] == 5'd0) ? 32'd0 : mirror[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        e = '0;
        e.rd = instr[11:7];
        e.store_data = b;
        e.check_alu = 1'b1;
        case (instr[6:0])
            rv_pipe_pkg::op_lui: begin
                e.reg_write = 1'b1;
                e.alu_result = {instr[31:12], 12'd0};
            end
            rv_pipe_pkg::op_auipc: begin
                e.reg_write = 1'b1;
                e.alu_result = pc + {instr[31:12], 12'd0};
            end
            rv_pipe_pkg::op_jal, rv_pipe_pkg::op_jalr: begin
                e.reg_write = 1'b1;
                e.wb_sel = rv_pipe_pkg::wb_sel_pc4;
                e.alu_result = pc + 32'd4;
                e.redirect = 1'b1;
                if (instr[6:0] == rv_pipe_pkg::op_jal) e.redirect_pc = pc + imm_j;
                else e.redirect_pc = (a + imm_i) & 32'hffff_fffe;
            end
            rv_pipe_pkg::op_branch: begin
                case (instr[14:12])
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    default: taken = a >= b;
                endcase
                e.check_alu = 1'b0;
                e.redirect = taken != est;
                e.redirect_pc = taken ? pc + imm_b : pc + 32'd4;
            end
            rv_pipe_pkg::op_load: begin
                e.reg_write = 1'b1;
                e.mem_read = 1'b1;
                e.wb_sel = rv_pipe_pkg::wb_sel_mem;
                e.alu_result = a + imm_i;
            end
            rv_pipe_pkg::op_store: begin
                e.mem_write = 1'b1;
                e.alu_result = a + imm_s;
            end
            rv_pipe_pkg::op_imm: begin
                e.reg_write = 1'b1;
                e.alu_result = alu_calc(instr[14:12], instr[14:12] == 3'b101 && instr[30],
                                        a, imm_i);
            end
            rv_pipe_pkg::op_reg: begin
                e.reg_write = 1'b1;
                e.alu_result = alu_calc(instr[14:12], instr[30], a, b);
            end
            default: e.check_alu = 1'b0;
        endcase
        return e;
    endfunction

    task automatic build_instr(output logic [31:0] w);
        logic [31:0] pick;
        logic [31:0] src;
        pick = $random(seed);
        w = $random(seed);
        src = $random(seed);
        case (pick % 9)
            0: w[6:0] = rv_pipe_pkg::op_lui;
            1: w[6:0] = rv_pipe_pkg::op_auipc;
            2: w[6:0] = rv_pipe_pkg::op_jal;
            3: begin
                w[6:0] = rv_pipe_pkg::op_jalr;
                w[14:12] = 3'b000;
            end
            4: begin
                w[6:0] = rv_pipe_pkg::op_branch;
                if (w[14:13] == 2'b01) w[13] = 1'b0;
            end
            5: w[6:0] = rv_pipe_pkg::op_load;
            6: w[6:0] = rv_pipe_pkg::op_store;
            7: begin
                w[6:0] = rv_pipe_pkg::op_imm;
                if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[30] & w[14], 5'b0};
            end
            default: begin
                w[6:0] = rv_pipe_pkg::op_reg;
                w[31:25] = {1'b0, w[30] & (w[14:12] == 3'b000 || w[14:12] == 3'b101), 5'b0};
            end
        endcase
        // x0 as a source now and then
        if (src[2:0] == 3'd0) w[19:15] = 5'd0;
        if (src[5:3] == 3'd0) w[24:20] = 5'd0;
    endtask

    task automatic issue_random();
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] rnd;
        build_instr(w);
        pc = $random(seed) & 32'hffff_fffc;
        rnd = $random(seed);
        id_instruction <= w;
        id_pc <= pc;
        id_pc_plus_4 <= pc + 32'd4;
        id_branch_estimation <= rnd[0];
        stall <= 1'b0;
        flush <= 1'b0;
    endtask

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        if (actv !== expv) begin
            errors++;
            $display("FAIL %s expected %h actual %h at %0t", name, expv, actv, $time);
        end
    endtask

    // tracks what the id/ex register should hold after each edge
    always @(posedge clk) begin
        started = 1'b1;
        if (reset || flush || (!slot_bubble && slot_exp.redirect)) begin
            slot_bubble = 1'b1;
            slot_instr = rv_pipe_pkg::nop_instr;
        end else if (!stall) begin
            slot_bubble = 1'b0;
            slot_instr = id_instruction;
            slot_exp = ref_model(id_instruction, id_pc, id_branch_estimation);
        end
    end

    always @(negedge clk) begin
        if (started) begin
            checks++;
            compare_field("ex_instruction", slot_instr, ex_instruction);
            if (slot_bubble) begin
                compare_field("ex_register_write_enable", 1'b0, ex_register_write_enable);
                compare_field("ex_memory_read", 1'b0, ex_memory_read);
                compare_field("ex_memory_write", 1'b0, ex_memory_write);
                compare_field("redirect", 1'b0, redirect);
            end else begin
                compare_field("ex_rd", slot_exp.rd, ex_rd);
                compare_field("ex_register_write_enable", slot_exp.reg_write,
                              ex_register_write_enable);
                compare_field("ex_memory_read", slot_exp.mem_read, ex_memory_read);
                compare_field("ex_memory_write", slot_exp.mem_write, ex_memory_write);
                compare_field("ex_write_data_select", slot_exp.wb_sel, ex_write_data_select);
                compare_field("redirect", slot_exp.redirect, redirect);
                if (slot_exp.check_alu) begin
                    compare_field("ex_alu_result", slot_exp.alu_result, ex_alu_result);
                end
                if (slot_exp.mem_write) begin
                    compare_field("ex_store_data", slot_exp.store_data, ex_store_data);
                end
                if (slot_exp.redirect) begin
                    compare_field("redirect_pc", slot_exp.redirect_pc, redirect_pc);
                end
            end
        end
    end

    initial begin
        logic [31:0] data;
        logic [31:0] rnd;
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        id_pc = 32'd0;
        id_pc_plus_4 = 32'd4;
        id_branch_estimation = 1'b0;
        id_instruction = rv_pipe_pkg::nop_instr;
        wb_write_enable = 1'b0;
        wb_rd = 5'd0;
        wb_data = 32'd0;
        mirror[0] = 32'd0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // load every register through the write-back port
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            data = $random(seed);
            wb_write_enable <= 1'b1;
            wb_rd <= r[4:0];
            wb_data <= data;
            mirror[r] <= data;
        end

        // a write to x0 is dropped, the mirror keeps zero
        @(posedge clk);
        data = $random(seed);
        wb_rd <= 5'd0;
        wb_data <= data | 32'd1;
        @(posedge clk);
        wb_write_enable <= 1'b0;

        for (int i = 0; i < num_issue / 2; i++) begin
            @(posedge clk);
            issue_random();
        end

        // stall spans of one or two cycles, sometimes with a flush inside
        for (int i = 0; i < num_issue / 2; i++) begin
            @(posedge clk);
            issue_random();
            rnd = $random(seed);
            if (rnd[1:0] == 2'd0) begin
                for (int k = 0; k <= int'(rnd[2]); k++) begin
                    @(posedge clk);
                    stall <= 1'b1;
                    flush <= rnd[4 + k];
                end
            end
        end

        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        id_instruction <= rv_pipe_pkg::nop_instr;
        repeat (3) @(posedge clk);
        errors += u_rv_id_ex_top.u_id_ex_register.u_rv_id_ex_properties.failures;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (num_issue * 3 + 200) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", num_issue * 3 + 200);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* rv_id_ex.f */
rv_pipe_pkg.sv
id_ex_if.sv
instr_decoder.sv
register_file.sv
id_ex_register.sv
ex_stage.sv
rv_id_ex_top.sv
rv_id_ex_properties.sv
rv_id_ex_tb.sv

/* Bender.yml */
package:
  name: rv_id_ex

sources:
  - rv_pipe_pkg.sv
  - id_ex_if.sv
  - instr_decoder.sv
  - register_file.sv
  - id_ex_register.sv
  - ex_stage.sv
  - rv_id_ex_top.sv
  - target: test
    files:
      - rv_id_ex_properties.sv
      - rv_id_ex_tb.sv
